/* filelist.f */
+incdir+logic
logic/bm_pkg.sv
logic/bm_decoder.sv
logic/bm_regfile.sv
logic/bm_alu.sv
logic/bm_ctrl.sv
logic/bm_core.sv
test/tb_clkgen.sv
test/tb_bm_core.sv

/* logic/bm_alu.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bm_params.svh"

module bm_alu (
  input  bm_pkg::alu_op_e     alu_op_i,
  input  logic [`BM_XLEN-1:0] op_a_i,
  input  logic [`BM_XLEN-1:0] op_b_i,
  output logic [`BM_XLEN-1:0] result_o
);
  import bm_pkg::*;

  localparam int SW = $clog2(`BM_XLEN);     // Shift amount width
  localparam int CW = $clog2(`BM_XLEN) + 1; // Count width, must hold XLEN

  logic [SW-1:0]         shamt;
  logic [`BM_XLEN-1:0]   bit_mask;
  logic [2*`BM_XLEN-1:0] rol_w;
  logic [2*`BM_XLEN-1:0] ror_w;
  logic                  lt_s;
  logic                  lt_u;
  logic [CW-1:0]         clz_cnt;
  logic [CW-1:0]         ctz_cnt;
  logic [CW-1:0]         cpop_cnt;
  logic [`BM_XLEN-1:0]   orc_w;
  logic [`BM_XLEN-1:0]   rev_w;

  assign shamt    = op_b_i[SW-1:0];                 // Rotates and Zbs use low bits only
  assign bit_mask = `BM_XLEN'(1) << shamt;
  assign rol_w    = {op_a_i, op_a_i} << shamt;      // Upper half is the rotated word
  assign ror_w    = {op_a_i, op_a_i} >> shamt;      // Lower half
  assign lt_s     = $signed(op_a_i) < $signed(op_b_i);
  assign lt_u     = op_a_i < op_b_i;

  ////////////////////
  // Bit counts

  always_comb begin
    clz_cnt  = CW'(`BM_XLEN); // Zero input counts as all zeros
    ctz_cnt  = CW'(`BM_XLEN);
    cpop_cnt = '0;
    for (int i = 0; i < `BM_XLEN; i++) begin
      if (op_a_i[i]) begin
        clz_cnt = CW'(`BM_XLEN - 1 - i); // Highest set bit wins
      end
      cpop_cnt = cpop_cnt + CW'(op_a_i[i]);
    end
    for (int i = `BM_XLEN - 1; i >= 0; i--) begin
      if (op_a_i[i]) begin
        ctz_cnt = CW'(i);                // Lowest set bit wins
      end
    end
  end

  ////////////////////
  // Byte ops

  always_comb begin
    for (int b = 0; b < `BM_XLEN / 8; b++) begin
      orc_w[8*b +: 8] = {8{|op_a_i[8*b +: 8]}};        // Byte OR-combine
      rev_w[8*b +: 8] = op_a_i[`BM_XLEN-8-8*b +: 8];    // Byte swap
    end
  end

  ////////////////////
  // Result select

  always_comb begin
    unique case (alu_op_i)
      SH1ADD:  result_o = (op_a_i << 1) + op_b_i;
      SH2ADD:  result_o = (op_a_i << 2) + op_b_i;
      SH3ADD:  result_o = (op_a_i << 3) + op_b_i;
      MIN:     result_o = lt_s ? op_a_i : op_b_i;
      MINU:    result_o = lt_u ? op_a_i : op_b_i;
      MAX:     result_o = lt_s ? op_b_i : op_a_i;
      MAXU:    result_o = lt_u ? op_b_i : op_a_i;
      ANDN:    result_o = op_a_i & ~op_b_i;
      ORN:     result_o = op_a_i | ~op_b_i;
      XNOR:    result_o = ~(op_a_i ^ op_b_i);
      ROL:     result_o = rol_w[2*`BM_XLEN-1:`BM_XLEN];
      ROR:     result_o = ror_w[`BM_XLEN-1:0];
      ZEXT_H:  result_o = `BM_XLEN'(op_a_i[15:0]);
      SEXT_B:  result_o = `BM_XLEN'($signed(op_a_i[7:0]));  // Signed cast extends the sign
      SEXT_H:  result_o = `BM_XLEN'($signed(op_a_i[15:0]));
      CLZ:     result_o = `BM_XLEN'(clz_cnt);
      CTZ:     result_o = `BM_XLEN'(ctz_cnt);
      CPOP:    result_o = `BM_XLEN'(cpop_cnt);
      ORC_B:   result_o = orc_w;
      REV8:    result_o = rev_w;
      BSET:    result_o = op_a_i | bit_mask;
      BCLR:    result_o = op_a_i & ~bit_mask;
      BINV:    result_o = op_a_i ^ bit_mask;
      BEXT:    result_o = `BM_XLEN'(op_a_i[shamt]);
      default: result_o = '0; // ALU_NOP
    endcase
  end

endmodule : bm_alu

`default_nettype wire

/* logic/bm_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bm_params.svh"

module bm_core (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                instr_valid_i,
  input  logic [31:0]         instr_i,
  input  logic                reg_we_i,     // Host preload
  input  logic [4:0]          reg_waddr_i,
  input  logic [`BM_XLEN-1:0] reg_wdata_i,
  output logic                wb_valid_o,   // Writeback pulse
  output logic [4:0]          wb_addr_o,
  output logic [`BM_XLEN-1:0] wb_data_o,
  output logic                illegal_o,
  output logic                busy_o
);
  import bm_pkg::*;

  instr_u              instr_w;
  dec_ctrl_t           dec_ctrl_w;
  logic [4:0]          raddr_a_w;
  logic [4:0]          raddr_b_w;
  logic [`BM_XLEN-1:0] rdata_a_w;
  logic [`BM_XLEN-1:0] rdata_b_w;
  logic                rf_we_w;
  logic [4:0]          rf_waddr_w;
  logic [`BM_XLEN-1:0] rf_wdata_w;
  alu_op_e             alu_op_w;
  logic [`BM_XLEN-1:0] op_a_w;
  logic [`BM_XLEN-1:0] op_b_w;
  logic [`BM_XLEN-1:0] result_w;

  bm_ctrl i_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .reg_we_i      (reg_we_i),
    .reg_waddr_i   (reg_waddr_i),
    .reg_wdata_i   (reg_wdata_i),
    .instr_o       (instr_w),
    .dec_ctrl_i    (dec_ctrl_w),
    .raddr_a_o     (raddr_a_w),
    .raddr_b_o     (raddr_b_w),
    .rdata_a_i     (rdata_a_w),
    .rdata_b_i     (rdata_b_w),
    .rf_we_o       (rf_we_w),
    .rf_waddr_o    (rf_waddr_w),
    .rf_wdata_o    (rf_wdata_w),
    .alu_op_o      (alu_op_w),
    .op_a_o        (op_a_w),
    .op_b_o        (op_b_w),
    .result_i      (result_w),
    .wb_valid_o    (wb_valid_o),
    .wb_addr_o     (wb_addr_o),
    .wb_data_o     (wb_data_o),
    .illegal_o     (illegal_o),
    .busy_o        (busy_o)
  );

  bm_decoder i_decoder (
    .instr_i    (instr_w),
    .dec_ctrl_o (dec_ctrl_w)
  );

  bm_regfile i_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (raddr_a_w),
    .raddr_b_i (raddr_b_w),
    .rdata_a_o (rdata_a_w),
    .rdata_b_o (rdata_b_w),
    .we_i      (rf_we_w),
    .waddr_i   (rf_waddr_w),
    .wdata_i   (rf_wdata_w)
  );

  bm_alu i_alu (
    .alu_op_i (alu_op_w),
    .op_a_i   (op_a_w),
    .op_b_i   (op_b_w),
    .result_o (result_w)
  );

endmodule : bm_core

`default_nettype wire

/* logic/bm_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bm_params.svh"

module bm_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Host side
  input  logic                instr_valid_i,
  input  logic [31:0]         instr_i,
  input  logic                reg_we_i,
  input  logic [4:0]          reg_waddr_i,
  input  logic [`BM_XLEN-1:0] reg_wdata_i,
  // Decoder
  output bm_pkg::instr_u      instr_o,
  input  bm_pkg::dec_ctrl_t   dec_ctrl_i,
  // Register file
  output logic [4:0]          raddr_a_o,
  output logic [4:0]          raddr_b_o,
  input  logic [`BM_XLEN-1:0] rdata_a_i,
  input  logic [`BM_XLEN-1:0] rdata_b_i,
  output logic                rf_we_o,
  output logic [4:0]          rf_waddr_o,
  output logic [`BM_XLEN-1:0] rf_wdata_o,
  // ALU
  output bm_pkg::alu_op_e     alu_op_o,
  output logic [`BM_XLEN-1:0] op_a_o,
  output logic [`BM_XLEN-1:0] op_b_o,
  input  logic [`BM_XLEN-1:0] result_i,
  // Writeback and status
  output logic                wb_valid_o,
  output logic [4:0]          wb_addr_o,
  output logic [`BM_XLEN-1:0] wb_data_o,
  output logic                illegal_o,
  output logic                busy_o
);
  import bm_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_WB} state_e;

  state_e              state_q;
  instr_u              instr_q;   // Held until WB for rd
  logic [`BM_XLEN-1:0] result_q;
  logic                we_q;      // Decoded rf_we, registered in EXEC
  logic                illegal_q;
  logic                wb_phase;

  ////////////////////
  // FSM

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      we_q      <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (instr_valid_i) begin
            state_q <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          state_q   <= ST_WB;
          we_q      <= dec_ctrl_i.rf_we;
          illegal_q <= dec_ctrl_i.illegal;
        end
        default: state_q <= ST_IDLE; // WB always returns to idle
      endcase
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_IDLE) && instr_valid_i) begin
      instr_q <= instr_i;
    end
    if (state_q == ST_EXEC) begin
      result_q <= result_i;
    end
  end

  ////////////////////
  // Operands

  assign instr_o   = instr_q;
  assign raddr_a_o = dec_ctrl_i.rf_re[0] ? instr_q.r.rs1 : 5'd0; // Unused port parks on x0
  assign raddr_b_o = dec_ctrl_i.rf_re[1] ? instr_q.r.rs2 : 5'd0;
  assign alu_op_o  = dec_ctrl_i.alu_en ? dec_ctrl_i.alu_op : ALU_NOP;
  assign op_a_o    = rdata_a_i;

  always_comb begin
    unique case (dec_ctrl_i.op_b_sel)
      OP_B_REG: op_b_o = rdata_b_i;
      OP_B_IMM: op_b_o = `BM_XLEN'(instr_q.i.imm12[4:0]); // shamt, zero-extended
      default:  op_b_o = '0;
    endcase
  end

  ////////////////////
  // Writeback and write port arbitration

  assign wb_phase   = (state_q == ST_WB);
  assign busy_o     = (state_q != ST_IDLE);
  assign wb_valid_o = wb_phase & we_q;
  assign illegal_o  = wb_phase & illegal_q;
  assign wb_addr_o  = instr_q.r.rd;
  assign wb_data_o  = result_q;

  // Host writes only when idle, so the two never collide
  assign rf_we_o    = wb_phase ? we_q : (!busy_o & reg_we_i);
  assign rf_waddr_o = wb_phase ? instr_q.r.rd : reg_waddr_i;
  assign rf_wdata_o = wb_phase ? result_q : reg_wdata_i;

endmodule : bm_ctrl

`default_nettype wire

/* logic/bm_decoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bm_params.svh"

module bm_decoder (
  input  bm_pkg::instr_u    instr_i,
  output bm_pkg::dec_ctrl_t dec_ctrl_o
);
  import bm_pkg::*;

  logic ext_ok; // Match found and its subset is built in

  always_comb begin
    dec_ctrl_o         = DEC_CTRL_ILLEGAL;
    dec_ctrl_o.illegal = 1'b0;
    ext_ok             = 1'b0;

    unique case (instr_i.r.opcode) // Opcode sits at the same place in both views
      OPCODE_OP: begin
        dec_ctrl_o.alu_en   = 1'b1;
        dec_ctrl_o.op_b_sel = OP_B_REG;
        dec_ctrl_o.rf_re    = 2'b11;
        dec_ctrl_o.rf_we    = 1'b1;

        unique case ({instr_i.r.funct7, instr_i.r.funct3})
          {7'b0010000, 3'b010}: dec_ctrl_o.alu_op = SH1ADD;
          {7'b0010000, 3'b100}: dec_ctrl_o.alu_op = SH2ADD;
          {7'b0010000, 3'b110}: dec_ctrl_o.alu_op = SH3ADD;
          {7'b0000101, 3'b100}: dec_ctrl_o.alu_op = MIN;
          {7'b0000101, 3'b101}: dec_ctrl_o.alu_op = MINU;
          {7'b0000101, 3'b110}: dec_ctrl_o.alu_op = MAX;
          {7'b0000101, 3'b111}: dec_ctrl_o.alu_op = MAXU;
          {7'b0100000, 3'b111}: dec_ctrl_o.alu_op = ANDN;
          {7'b0100000, 3'b110}: dec_ctrl_o.alu_op = ORN;
          {7'b0100000, 3'b100}: dec_ctrl_o.alu_op = XNOR;
          {7'b0110000, 3'b001}: dec_ctrl_o.alu_op = ROL;
          {7'b0110000, 3'b101}: dec_ctrl_o.alu_op = ROR;
          {7'b0000100, 3'b100}: dec_ctrl_o.alu_op = ZEXT_H;   // Encoded as pack with rs2 = x0
          {7'b0010100, 3'b001}: dec_ctrl_o.alu_op = BSET;
          {7'b0100100, 3'b001}: dec_ctrl_o.alu_op = BCLR;
          {7'b0110100, 3'b001}: dec_ctrl_o.alu_op = BINV;
          {7'b0100100, 3'b101}: dec_ctrl_o.alu_op = BEXT;
          default:              dec_ctrl_o.alu_op = ALU_NOP;  // No match
        endcase

        // zext.h reads only rs1
        if (dec_ctrl_o.alu_op == ZEXT_H) begin
          dec_ctrl_o.op_b_sel = OP_B_NONE;
          dec_ctrl_o.rf_re[1] = 1'b0;
          if (instr_i.r.rs2 != 5'd0) begin
            dec_ctrl_o.alu_op = ALU_NOP; // rs2 field must be x0
          end
        end
      end

      OPCODE_OPIMM: begin
        dec_ctrl_o.alu_en = 1'b1;
        dec_ctrl_o.rf_re  = 2'b01; // rs1 only
        dec_ctrl_o.rf_we  = 1'b1;

        // imm12[4:0] is rs2 for unary ops and shamt otherwise
        unique casez ({instr_i.i.imm12, instr_i.i.funct3})
          {7'b0110000, 5'b00000, 3'b001}: dec_ctrl_o.alu_op = CLZ;
          {7'b0110000, 5'b00001, 3'b001}: dec_ctrl_o.alu_op = CTZ;
          {7'b0110000, 5'b00010, 3'b001}: dec_ctrl_o.alu_op = CPOP;
          {7'b0110000, 5'b00100, 3'b001}: dec_ctrl_o.alu_op = SEXT_B;
          {7'b0110000, 5'b00101, 3'b001}: dec_ctrl_o.alu_op = SEXT_H;
          {7'b0010100, 5'b00111, 3'b101}: dec_ctrl_o.alu_op = ORC_B;
          {7'b0110100, 5'b11000, 3'b101}: dec_ctrl_o.alu_op = REV8;
          {7'b0110000, 5'b?????, 3'b101}: dec_ctrl_o.alu_op = ROR;   // rori
          {7'b0010100, 5'b?????, 3'b001}: dec_ctrl_o.alu_op = BSET;  // bseti
          {7'b0100100, 5'b?????, 3'b001}: dec_ctrl_o.alu_op = BCLR;  // bclri
          {7'b0110100, 5'b?????, 3'b001}: dec_ctrl_o.alu_op = BINV;  // binvi
          {7'b0100100, 5'b?????, 3'b101}: dec_ctrl_o.alu_op = BEXT;  // bexti
          default:                        dec_ctrl_o.alu_op = ALU_NOP;
        endcase

        // Shift-amount forms take the immediate, the rest are unary
        dec_ctrl_o.op_b_sel = (dec_ctrl_o.alu_op inside {ROR, BSET, BCLR, BINV, BEXT}) ?
                              OP_B_IMM : OP_B_NONE;
      end

      default: dec_ctrl_o.alu_op = ALU_NOP; // Not a B-extension opcode
    endcase

    // Subset gating
    if (dec_ctrl_o.alu_op inside {SH1ADD, SH2ADD, SH3ADD}) begin
      ext_ok = (`BM_ZBA_EN != 0);
    end else if (dec_ctrl_o.alu_op inside {BSET, BCLR, BINV, BEXT}) begin
      ext_ok = (`BM_ZBS_EN != 0);
    end else if (dec_ctrl_o.alu_op != ALU_NOP) begin
      ext_ok = (`BM_ZBB_EN != 0);
    end

    if (!ext_ok) begin
      dec_ctrl_o = DEC_CTRL_ILLEGAL; // Unknown or disabled
    end
  end

endmodule : bm_decoder

`default_nettype wire

/* logic/bm_params.svh */
`ifndef BM_PARAMS_SVH
`define BM_PARAMS_SVH

// Datapath width and register file depth
`define BM_XLEN   32
`define BM_NREGS  32

// Subset enables (0 drops the subset from the decoder)
`define BM_ZBA_EN 1 // Address generation
`define BM_ZBB_EN 1 // Basic bit manipulation
`define BM_ZBS_EN 1 // Single-bit operations

`endif

/* logic/bm_pkg.sv */
`default_nettype none

package bm_pkg;

  // Major opcodes
  localparam logic [6:0] OPCODE_OP    = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;

  // ALU operators
  typedef enum logic [4:0] {
    ALU_NOP,
    SH1ADD, SH2ADD, SH3ADD,             // Zba
    MIN, MINU, MAX, MAXU,               // Zbb compare
    ANDN, ORN, XNOR,                    // Zbb logic with negate
    ROL, ROR,                           // Zbb rotates
    ZEXT_H, SEXT_B, SEXT_H,             // Zbb extends
    CLZ, CTZ, CPOP,                     // Zbb counts
    ORC_B, REV8,                        // Zbb byte ops
    BSET, BCLR, BINV, BEXT              // Zbs
  } alu_op_e;

  // Operand B source
  typedef enum logic [1:0] {
    OP_B_REG,   // rs2
    OP_B_IMM,   // Shift amount from imm12
    OP_B_NONE   // Unary op
  } op_b_sel_e;

  // Decoder output, 12 bits
  typedef struct packed {
    logic      alu_en;
    alu_op_e   alu_op;
    op_b_sel_e op_b_sel;
    logic [1:0] rf_re;   // [0] rs1, [1] rs2
    logic      rf_we;
    logic      illegal;
  } dec_ctrl_t;

  localparam dec_ctrl_t DEC_CTRL_ILLEGAL = '{
    alu_en   : 1'b0,
    alu_op   : ALU_NOP,
    op_b_sel : OP_B_NONE,
    rf_re    : 2'b00,
    rf_we    : 1'b0,
    illegal  : 1'b1
  };

  // R-type view
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  // I-type view
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // One instruction word, two decodings
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

`default_nettype wire

/* logic/bm_regfile.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bm_params.svh"

module bm_regfile (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Read ports
  input  logic [4:0]          raddr_a_i,
  input  logic [4:0]          raddr_b_i,
  output logic [`BM_XLEN-1:0] rdata_a_o,
  output logic [`BM_XLEN-1:0] rdata_b_o,
  // Write port
  input  logic                we_i,
  input  logic [4:0]          waddr_i,
  input  logic [`BM_XLEN-1:0] wdata_i
);

  logic [`BM_XLEN-1:0] regs_q [1:`BM_NREGS-1]; // x0 has no storage

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `BM_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin // Writes to x0 dropped
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads, x0 hardwired
  assign rdata_a_o = (raddr_a_i == 5'd0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 5'd0) ? '0 : regs_q[raddr_b_i];

endmodule : bm_regfile

`default_nettype wire

/* test/tb_bm_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bm_params.svh"

module tb_bm_core;
  import bm_pkg::*;

  localparam int WAIT_LIMIT = 20; // Cycles before any wait gives up
  localparam int DRIVE_DLY  = 2;  // Input skew after the rising edge

  logic                clk;
  logic                rst_n;
  logic                instr_valid;
  logic [31:0]         instr;
  logic                reg_we;
  logic [4:0]          reg_waddr;
  logic [`BM_XLEN-1:0] reg_wdata;
  logic                wb_valid;
  logic [4:0]          wb_addr;
  logic [`BM_XLEN-1:0] wb_data;
  logic                illegal;
  logic                busy;

  logic [31:0] shadow [0:31]; // Expected register contents
  logic [31:0] rng_state;
  int          checks;
  int          errors;

  tb_clkgen #(.PERIOD_NS(40)) i_clkgen (.clk_o(clk));

  bm_core i_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .reg_we_i      (reg_we),
    .reg_waddr_i   (reg_waddr),
    .reg_wdata_i   (reg_wdata),
    .wb_valid_o    (wb_valid),
    .wb_addr_o     (wb_addr),
    .wb_data_o     (wb_data),
    .illegal_o     (illegal),
    .busy_o        (busy)
  );

  ////////////////////
  // Stimulus helpers

  function automatic logic [31:0] next_rand(); // xorshift32
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [4:0] pick_reg(); // Any of x1..x31
    logic [31:0] r;
    r = next_rand();
    return 5'(1 + (r % 31));
  endfunction

  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011}; // OP major opcode
  endfunction

  // The lo field holds the shift amount or the unary selector
  function automatic logic [31:0] i_type_word(input logic [6:0] f7, input logic [4:0] lo,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {f7, lo, rs1, f3, rd, 7'b0010011}; // OP-IMM major opcode
  endfunction

  ////////////////////
  // Reference model

  function automatic logic [31:0] model_result(input alu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
    logic [31:0] r;
    int          sh;
    int          n;
    sh = int'(b[4:0]);
    r  = '0;
    n  = 0;
    case (op)
      SH1ADD: r = a * 2 + b;
      SH2ADD: r = a * 4 + b;
      SH3ADD: r = a * 8 + b;
      MIN:    r = ($signed(a) < $signed(b)) ? a : b;
      MINU:   r = (a < b) ? a : b;
      MAX:    r = ($signed(a) > $signed(b)) ? a : b;
      MAXU:   r = (a > b) ? a : b;
      ANDN:   r = a & ~b;
      ORN:    r = a | ~b;
      XNOR:   r = a ~^ b;
      ROL:    r = (a << sh) | (a >> (32 - sh)); // Shift by 32 yields zero
      ROR:    r = (a >> sh) | (a << (32 - sh));
      ZEXT_H: r = {16'h0000, a[15:0]};
      SEXT_B: r = {{24{a[7]}}, a[7:0]};
      SEXT_H: r = {{16{a[15]}}, a[15:0]};
      CLZ: begin
        while (n < 32 && !a[31 - n]) n++; // Stops at 32 for zero
        r = n;
      end
      CTZ: begin
        while (n < 32 && !a[n]) n++;
        r = n;
      end
      CPOP: begin
        for (int i = 0; i < 32; i++) n += a[i];
        r = n;
      end
      ORC_B: begin
        for (int k = 0; k < 4; k++) r[8*k +: 8] = (a[8*k +: 8] != 0) ? 8'hff : 8'h00;
      end
      REV8:   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      BSET:   r = a | (32'h1 << sh);
      BCLR:   r = a & ~(32'h1 << sh);
      BINV:   r = a ^ (32'h1 << sh);
      BEXT:   r = {31'h0, a[sh]};
      default: r = '0;
    endcase
    return r;
  endfunction

  ////////////////////
  // Checking and run control

  task automatic report_and_finish();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, WAIT_LIMIT);
    errors++;
    report_and_finish();
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp_val);
    checks++;
    assert (got === exp_val) else begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp_val);
      errors++;
    end
  endtask

  task automatic expect_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("Error at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
  endtask

  task automatic wait_until_idle();
    int n;
    n = 0;
    while (busy && n < WAIT_LIMIT) begin
      @(negedge clk); // Mid-cycle sample
      n++;
    end
    if (busy) begin
      abort_on_timeout("busy_o falling");
    end
  endtask

  task automatic preload_reg(input logic [4:0] addr, input logic [31:0] data);
    wait_until_idle();
    @(posedge clk);
    #DRIVE_DLY;
    reg_we    = 1'b1;
    reg_waddr = addr;
    reg_wdata = data;
    @(posedge clk);
    #DRIVE_DLY;
    reg_we    = 1'b0;
    if (addr != 5'd0) shadow[addr] = data; // x0 stays zero
  endtask

  // Issue one instruction and check its result pulse
  task automatic issue_and_check(input logic [31:0] word, input bit exp_illegal,
                                 input logic [31:0] exp_data);
    int         lat;
    logic [4:0] rd;
    rd = word[11:7];
    wait_until_idle();
    @(posedge clk);
    #DRIVE_DLY;
    instr_valid = 1'b1;
    instr       = word;
    @(posedge clk); // DUT samples the strobe here
    #DRIVE_DLY;
    instr_valid = 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      compare("busy_o", busy, 1'b1); // High while in flight
    end while (!wb_valid && !illegal && lat < WAIT_LIMIT);
    if (!wb_valid && !illegal) begin
      abort_on_timeout("writeback or illegal pulse");
    end else begin
      compare("result latency", lat, 2);
      compare("illegal_o", illegal, exp_illegal);
      compare("wb_valid_o", wb_valid, !exp_illegal);
      if (!exp_illegal) begin
        compare("wb_addr_o", wb_addr, rd);
        compare("wb_data_o", wb_data, exp_data);
        if (rd != 5'd0) shadow[rd] = exp_data;
      end
      @(negedge clk);
      expect_true(!wb_valid && !illegal, "result pulse lasted longer than one cycle");
      compare("busy_o", busy, 1'b0); // Idle again right after the pulse
    end
  endtask

  task automatic read_back(input logic [4:0] r); // maxu x0, r, r returns r unchanged
    issue_and_check(r_type_word(7'b0000101, r, r, 3'b111, 5'd0), 1'b0, shadow[r]);
  endtask

  task automatic register_op(input alu_op_e op, input logic [6:0] f7, input logic [2:0] f3);
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    rs1 = pick_reg();
    rs2 = (op == ZEXT_H) ? 5'd0 : pick_reg(); // zext.h needs rs2 = x0
    rd  = pick_reg();
    preload_reg(rs1, next_rand());
    if (rs2 != 5'd0) preload_reg(rs2, next_rand());
    issue_and_check(r_type_word(f7, rs2, rs1, f3, rd), 1'b0,
                    model_result(op, shadow[rs1], shadow[rs2]));
  endtask

  task automatic immediate_op(input alu_op_e op, input logic [6:0] f7, input logic [4:0] lo,
                              input logic [2:0] f3, input logic [31:0] a);
    logic [4:0] rs1;
    logic [4:0] rd;
    rs1 = pick_reg();
    rd  = pick_reg();
    preload_reg(rs1, a);
    issue_and_check(i_type_word(f7, lo, rs1, f3, rd), 1'b0, model_result(op, a, {27'h0, lo}));
  endtask

  ////////////////////
  // Directed tests

  task automatic check_reset_idle();
    compare("busy_o", busy, 1'b0);
    compare("wb_valid_o", wb_valid, 1'b0);
    compare("illegal_o", illegal, 1'b0);
    for (int r = 0; r < 32; r++) begin // sh1add x0, r, x0
      issue_and_check(r_type_word(7'b0010000, 5'd0, 5'(r), 3'b010, 5'd0), 1'b0,
                      model_result(SH1ADD, shadow[r], 32'h0));
    end
  endtask

  task automatic run_register_ops();
    repeat (2) begin
      register_op(SH1ADD, 7'b0010000, 3'b010);
      register_op(SH2ADD, 7'b0010000, 3'b100);
      register_op(SH3ADD, 7'b0010000, 3'b110);
      register_op(MIN,    7'b0000101, 3'b100);
      register_op(MINU,   7'b0000101, 3'b101);
      register_op(MAX,    7'b0000101, 3'b110);
      register_op(MAXU,   7'b0000101, 3'b111);
      register_op(ANDN,   7'b0100000, 3'b111);
      register_op(ORN,    7'b0100000, 3'b110);
      register_op(XNOR,   7'b0100000, 3'b100);
      register_op(ROL,    7'b0110000, 3'b001);
      register_op(ROR,    7'b0110000, 3'b101);
      register_op(ZEXT_H, 7'b0000100, 3'b100);
      register_op(BSET,   7'b0010100, 3'b001);
      register_op(BCLR,   7'b0100100, 3'b001);
      register_op(BINV,   7'b0110100, 3'b001);
      register_op(BEXT,   7'b0100100, 3'b101);
    end
  endtask

  task automatic run_immediate_ops();
    logic [31:0] a;
    logic [31:0] r;
    logic [4:0]  sh;
    for (int k = 0; k < 3; k++) begin
      a  = (k == 0) ? 32'h0 : (k == 1) ? 32'hffff_ffff : next_rand(); // Edge values first
      r  = next_rand();
      sh = r[4:0];
      immediate_op(CLZ,    7'b0110000, 5'd0,  3'b001, a);
      immediate_op(CTZ,    7'b0110000, 5'd1,  3'b001, a);
      immediate_op(CPOP,   7'b0110000, 5'd2,  3'b001, a);
      immediate_op(SEXT_B, 7'b0110000, 5'd4,  3'b001, a);
      immediate_op(SEXT_H, 7'b0110000, 5'd5,  3'b001, a);
      immediate_op(ORC_B,  7'b0010100, 5'd7,  3'b101, a);
      immediate_op(REV8,   7'b0110100, 5'd24, 3'b101, a);
      immediate_op(ROR,    7'b0110000, sh,    3'b101, a); // rori
      immediate_op(BSET,   7'b0010100, sh,    3'b001, a); // bseti
      immediate_op(BCLR,   7'b0100100, sh,    3'b001, a); // bclri
      immediate_op(BINV,   7'b0110100, sh,    3'b001, a); // binvi
      immediate_op(BEXT,   7'b0100100, sh,    3'b101, a); // bexti
    end
  endtask

  task automatic chain_dependent_ops();
    logic [31:0] first;
    logic [31:0] second;
    preload_reg(5'd5, next_rand());
    preload_reg(5'd6, next_rand());
    first = model_result(ANDN, shadow[5], shadow[6]);
    issue_and_check(r_type_word(7'b0100000, 5'd6, 5'd5, 3'b111, 5'd7), 1'b0, first);
    second = model_result(CPOP, first, 32'h0);  // Reads x7 right after its writeback
    issue_and_check(i_type_word(7'b0110000, 5'd2, 5'd7, 3'b001, 5'd8), 1'b0, second);
    // rol x7, x7, x8 overwrites its own source
    issue_and_check(r_type_word(7'b0110000, 5'd8, 5'd7, 3'b001, 5'd7), 1'b0,
                    model_result(ROL, first, second));
    // Result to x0 is reported but not stored
    issue_and_check(r_type_word(7'b0010000, 5'd8, 5'd7, 3'b100, 5'd0), 1'b0,
                    model_result(SH2ADD, shadow[7], shadow[8]));
    read_back(5'd0);
    read_back(5'd7);
    read_back(5'd8);
  endtask

  task automatic reject_illegal_encodings();
    preload_reg(5'd9, next_rand()); // Target of every rejected instruction
    preload_reg(5'd1, next_rand());
    issue_and_check(r_type_word(7'b1111111, 5'd2, 5'd1, 3'b000, 5'd9), 1'b1, 32'h0);
    issue_and_check(r_type_word(7'b0000100, 5'd3, 5'd1, 3'b100, 5'd9), 1'b1, 32'h0);
    issue_and_check({12'h000, 5'd1, 3'b010, 5'd9, 7'b0000011}, 1'b1, 32'h0); // lw
    for (int r = 0; r < 32; r++) begin
      read_back(5'(r)); // Nothing may have moved
    end
  endtask

  ////////////////////
  // Main sequence

  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    reg_we      = 1'b0;
    reg_waddr   = '0;
    reg_wdata   = '0;
    rst_n       = 1'b0;
    rng_state   = 32'd26098;
    checks      = 0;
    errors      = 0;
    for (int r = 0; r < 32; r++) shadow[r] = '0; // Reset value of every register
    apply_reset();
    check_reset_idle();
    run_register_ops();
    run_immediate_ops();
    chain_dependent_ops();
    reject_illegal_encodings();
    report_and_finish();
  end

endmodule : tb_bm_core

`default_nettype wire

/* test/tb_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS = 40 // Full clock period
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o; // Half period per phase
    end
  end

endmodule : tb_clkgen

`default_nettype wire
